// File: common/queue_pkg.sv
package queue_pkg;

    // ************************************************************************
    // Default sizes
    // ************************************************************************

    // Word width of the receive and transmit streams.
    localparam int DEFAULT_WIDTH = 8;

    // Number of words in the buffer; a power of two and no less than 4.
    localparam int DEFAULT_CAPACITY = 16;

    // ************************************************************************
    // Shared types
    // ************************************************************************

    // Single-bit strobe or flag passed between blocks.
    typedef logic flag_t;

    // Status derived from the registered occupancy.
    typedef struct packed {
        flag_t empty;        // No words are stored.
        flag_t almost_full;  // At most two free slots remain.
    } queue_status_t;

    // States of the transmit side machine.
    typedef enum logic [0:0] {
        READ_IDLE = 1'b0,    // Nothing is presented on the transmit port.
        READ_DATA = 1'b1     // The memory output holds a valid word.
    } read_state_t;

endpackage

// File: source/queue_write_stage.sv
`timescale 1ns/1ps

module queue_write_stage #(
    parameter int WIDTH = queue_pkg::DEFAULT_WIDTH
) (
    input  logic                     aclk,
    input  logic                     areset_n,
    input  logic                     rx_tvalid,
    input  logic [WIDTH-1:0]         rx_tdata,
    input  queue_pkg::queue_status_t status,
    output logic                     rx_tready,
    output queue_pkg::flag_t         write,
    output logic [WIDTH-1:0]         write_data
);

    // A receive transfer happens on any edge where both handshake
    // signals are high.
    logic rx_accept;

    assign rx_accept = rx_tvalid && rx_tready;

    // The write strobe lags the transfer by one cycle.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            write <= 1'b0;
        end else begin
            write <= rx_accept;
        end
    end

    // Ready is registered, so it drops one cycle after almost_full rises.
    // The threshold keeps enough headroom for the word still in flight.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_tready <= 1'b0;
        end else begin
            rx_tready <= !status.almost_full;
        end
    end

    // Payload register, loaded only when a word is taken.
    always_ff @(posedge aclk) begin
        if (rx_accept) begin
            write_data <= rx_tdata;  // Stored in the memory on the next edge.
        end
    end

endmodule

// File: queue_core/queue_memory.sv
`timescale 1ns/1ps

module queue_memory #(
    parameter int WIDTH    = queue_pkg::DEFAULT_WIDTH,
    parameter int CAPACITY = queue_pkg::DEFAULT_CAPACITY
) (
    input  logic                        aclk,
    input  queue_pkg::flag_t            write,
    input  logic [$clog2(CAPACITY)-1:0] write_address,
    input  logic [WIDTH-1:0]            write_data,
    input  queue_pkg::flag_t            read,
    input  logic [$clog2(CAPACITY)-1:0] read_address,
    output logic [WIDTH-1:0]            read_data
);

    // ************************************************************************
    // Storage array
    // ************************************************************************

    logic [WIDTH-1:0] storage [CAPACITY];

    // Synchronous write port.
    always_ff @(posedge aclk) begin
        if (write) begin
            storage[write_address] <= write_data;
        end
    end

    // ************************************************************************
    // Registered read port
    // ************************************************************************

    // The output register changes only when a read is requested, so the
    // word on the transmit port holds while the consumer stalls.
    // There is no show-ahead; data appears one edge after the request.
    always_ff @(posedge aclk) begin
        if (read) begin
            read_data <= storage[read_address];
        end
    end

    // The counter never lets a read target the slot being written in the
    // same cycle, since a slot only becomes readable after its write.

endmodule

// File: queue_core/queue_usage_counter.sv
`timescale 1ns/1ps

module queue_usage_counter #(
    parameter int CAPACITY = queue_pkg::DEFAULT_CAPACITY
) (
    input  logic                        aclk,
    input  logic                        areset_n,
    input  queue_pkg::flag_t            write,
    input  queue_pkg::flag_t            read,
    output logic [$clog2(CAPACITY)-1:0] write_address,
    output logic [$clog2(CAPACITY)-1:0] read_address,
    output queue_pkg::queue_status_t    status
);

    localparam int ADDRESS_WIDTH = $clog2(CAPACITY);

    // One extra bit so that a completely full buffer can be represented.
    localparam int COUNT_WIDTH = ADDRESS_WIDTH + 1;

    // Occupancy at which the receive side must stop accepting.
    localparam logic [COUNT_WIDTH-1:0] ALMOST_FULL_LEVEL = COUNT_WIDTH'(CAPACITY - 2);

    logic [ADDRESS_WIDTH-1:0] write_pointer;
    logic [ADDRESS_WIDTH-1:0] read_pointer;
    logic [COUNT_WIDTH-1:0]   count;

    // ************************************************************************
    // Pointers
    // ************************************************************************

    // Both pointers wrap on their own because CAPACITY is a power of two.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            write_pointer <= '0;
        end else if (write) begin
            write_pointer <= write_pointer + 1'b1;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            read_pointer <= '0;
        end else if (read) begin
            read_pointer <= read_pointer + 1'b1;
        end
    end

    assign write_address = write_pointer;
    assign read_address  = read_pointer;

    // ************************************************************************
    // Occupancy
    // ************************************************************************

    // A simultaneous write and read leaves the count unchanged.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            count <= '0;
        end else begin
            unique case ({write, read})
                2'b10: begin
                    count <= count + 1'b1;  // Write only.
                end
                2'b01: begin
                    count <= count - 1'b1;  // Read only.
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // Status comes straight from the registered count.
    always_comb begin
        status.empty       = (count == '0);
        status.almost_full = (count >= ALMOST_FULL_LEVEL);
    end

    // Reads are only issued while the queue is not empty, and writes stop
    // early enough, so the count stays within 0 and CAPACITY.

endmodule

// File: source/queue_read_fsm.sv
`timescale 1ns/1ps

module queue_read_fsm (
    input  logic                     aclk,
    input  logic                     areset_n,
    input  queue_pkg::queue_status_t status,
    input  logic                     tx_tready,
    output queue_pkg::flag_t         read,
    output logic                     tx_tvalid
);

    queue_pkg::read_state_t state;
    queue_pkg::read_state_t state_next;

    // ************************************************************************
    // State register
    // ************************************************************************

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            state <= queue_pkg::READ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ************************************************************************
    // Next state and read request
    // ************************************************************************

    // In IDLE the first stored word is prefetched into the memory output.
    // In DATA a new word is fetched only as the current one is taken.
    always_comb begin
        state_next = state;
        read       = 1'b0;

        unique case (state)
            queue_pkg::READ_IDLE: begin
                read = !status.empty;
                if (!status.empty) begin
                    state_next = queue_pkg::READ_DATA;
                end
            end
            queue_pkg::READ_DATA: begin
                read = tx_tready && !status.empty;
                if (tx_tready && status.empty) begin
                    state_next = queue_pkg::READ_IDLE;  // Last word leaves.
                end
            end
            default: begin
                state_next = queue_pkg::READ_IDLE;
            end
        endcase
    end

    // The memory output is valid for exactly as long as the machine is in
    // the DATA state.
    assign tx_tvalid = (state == queue_pkg::READ_DATA);

endmodule

// File: source/basic_queue.sv
`timescale 1ns/1ps

module basic_queue #(
    parameter int WIDTH    = queue_pkg::DEFAULT_WIDTH,
    parameter int CAPACITY = queue_pkg::DEFAULT_CAPACITY
) (
    input  logic             aclk,
    input  logic             areset_n,
    input  logic             rx_tvalid,
    input  logic [WIDTH-1:0] rx_tdata,
    output logic             rx_tready,
    input  logic             tx_tready,
    output logic             tx_tvalid,
    output logic [WIDTH-1:0] tx_tdata
);

    localparam int ADDRESS_WIDTH = $clog2(CAPACITY);

    queue_pkg::flag_t         write;
    queue_pkg::flag_t         read;
    queue_pkg::queue_status_t status;
    logic [WIDTH-1:0]         write_data;
    logic [ADDRESS_WIDTH-1:0] write_address;
    logic [ADDRESS_WIDTH-1:0] read_address;

    // ************************************************************************
    // Receive side
    // ************************************************************************

    queue_write_stage #(
        .WIDTH(WIDTH)
    ) u_write_stage (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .status    (status),
        .rx_tready (rx_tready),
        .write     (write),
        .write_data(write_data)
    );

    // ************************************************************************
    // Buffer and bookkeeping
    // ************************************************************************

    queue_usage_counter #(
        .CAPACITY(CAPACITY)
    ) u_usage_counter (
        .aclk         (aclk),
        .areset_n     (areset_n),
        .write        (write),
        .read         (read),
        .write_address(write_address),
        .read_address (read_address),
        .status       (status)
    );

    // The registered read output is the transmit data.
    queue_memory #(
        .WIDTH   (WIDTH),
        .CAPACITY(CAPACITY)
    ) u_memory (
        .aclk         (aclk),
        .write        (write),
        .write_address(write_address),
        .write_data   (write_data),
        .read         (read),
        .read_address (read_address),
        .read_data    (tx_tdata)
    );

    // Transmit side.
    queue_read_fsm u_read_fsm (
        .aclk     (aclk),
        .areset_n (areset_n),
        .status   (status),
        .tx_tready(tx_tready),
        .read     (read),
        .tx_tvalid(tx_tvalid)
    );

endmodule

// File: bench/queue_checker.sv
`timescale 1ns/1ps

module queue_checker #(
    parameter int WIDTH    = 8,
    parameter int CAPACITY = 16
) (
    input  logic             aclk,
    input  logic             areset_n,
    input  logic             rx_tvalid,
    input  logic [WIDTH-1:0] rx_tdata,
    input  logic             rx_tready,
    input  logic             tx_tvalid,
    input  logic [WIDTH-1:0] tx_tdata,
    input  logic             tx_tready,
    input  int               test_number,
    input  int               test_mode,
    output int               outstanding,
    output int               error_count,
    output int               tests_done,
    output int               words_checked
);

    localparam int MODE_NEVER  = 1;
    localparam int MODE_RANDOM = 2;

    logic [WIDTH-1:0] model [$];     // Words accepted and not yet transmitted.
    logic             stalled;       // Word offered but not taken at the last edge.
    logic [WIDTH-1:0] stalled_data;
    logic             after_reset;
    logic             saw_rx_stall;
    int               open_test;
    int               open_mode;
    int               test_errors;
    int               test_words;

    initial begin
        outstanding   = 0;
        error_count   = 0;
        tests_done    = 0;
        words_checked = 0;
        stalled       = 1'b0;
        stalled_data  = '0;
        after_reset   = 1'b1;
        saw_rx_stall  = 1'b0;
        open_test     = 0;
        open_mode     = 0;
        test_errors   = 0;
        test_words    = 0;
    end

    function automatic string mode_name(input int mode);
        case (mode)
            0: return "always";
            1: return "never";
            2: return "random";
            default: return "explicit";
        endcase
    endfunction

    task automatic report_failure(input string kind, input string text);
        $display("%s at %0t ns: %s", kind, $time, text);
        error_count++;
        test_errors++;
    endtask

    // A test closes on the first edge that shows a new test number.
    task automatic close_test();
        if (open_mode == MODE_NEVER && !saw_rx_stall) begin
            report_failure("Error", "rx_tready never fell while transmit was stalled");
        end
        if ((open_mode == MODE_RANDOM || test_number == 0) && model.size() != 0) begin
            report_failure("Error", $sformatf("%0d accepted words never came out",
                                              model.size()));
        end
        $display("Test %0d (%s): %0d words out, %0d errors", open_test,
                 mode_name(open_mode), test_words, test_errors);
        tests_done++;
    endtask

    // ************************************************************************
    // Sampling at the rising edge sees the values that decide each transfer.
    // ************************************************************************

    always @(posedge aclk) begin
        if (!areset_n) begin
            if (rx_tready || tx_tvalid) begin
                report_failure("Error", "rx_tready or tx_tvalid is high during reset");
            end
            after_reset = 1'b1;
        end else begin
            if (test_number != open_test) begin
                if (open_test != 0) begin
                    close_test();
                end
                open_test    = test_number;
                open_mode    = test_mode;
                test_errors  = 0;
                test_words   = 0;
                saw_rx_stall = 1'b0;
            end
            if (after_reset && (rx_tready || tx_tvalid)) begin
                report_failure("Error", "rx_tready or tx_tvalid is high just after reset");
            end
            after_reset = 1'b0;

            if (stalled && !tx_tvalid) begin
                report_failure("Error", "tx_tvalid fell before the word was taken");
            end else if (stalled && tx_tdata !== stalled_data) begin
                report_failure("Mismatch", $sformatf("tx_tdata moved from %h to %h while held",
                                                     stalled_data, tx_tdata));
            end
            stalled      = tx_tvalid && !tx_tready;
            stalled_data = tx_tdata;

            if (tx_tvalid && model.size() == 0) begin
                report_failure("Error", "tx_tvalid is high with no word outstanding");
            end else if (tx_tvalid && tx_tready) begin
                if (tx_tdata !== model[0]) begin
                    report_failure("Mismatch", $sformatf("expected %h, got %h on transmit",
                                                         model[0], tx_tdata));
                end
                void'(model.pop_front());
                words_checked++;
                test_words++;
            end

            if (rx_tvalid && rx_tready) begin
                model.push_back(rx_tdata);
            end
            if (!rx_tready) begin
                saw_rx_stall = 1'b1;
            end
            // Memory slots plus the word held on the transmit port.
            if (model.size() > CAPACITY + 1) begin
                report_failure("Error", "more words accepted than the queue can hold");
            end
            outstanding = model.size();
        end
    end

endmodule

// File: bench/basic_queue_tb.sv
`timescale 1ns/1ps

module basic_queue_tb;

    localparam int         WIDTH         = 8;
    localparam int         CAPACITY      = 16;
    localparam int         RESET_CYCLES  = 3;
    localparam int         DRAIN_CYCLES  = 2 * CAPACITY;
    localparam int         STIM_DEPTH    = 1024;
    localparam string      STIM_FILE     = "bench/queue_stim.txt";
    localparam logic [7:0] HEADER_MARK   = 8'hFF;
    localparam int         MODE_ALWAYS   = 0;
    localparam int         MODE_NEVER    = 1;
    localparam int         MODE_RANDOM   = 2;
    localparam int         MODE_EXPLICIT = 3;

    logic             aclk = 1'b0;
    logic             areset_n;
    logic             rx_tvalid;
    logic [WIDTH-1:0] rx_tdata;
    logic             rx_tready;
    logic             tx_tready;
    logic             tx_tvalid;
    logic [WIDTH-1:0] tx_tdata;

    logic [7:0]  stim [STIM_DEPTH];
    logic [31:0] lcg_state;
    int          test_number;
    int          test_mode;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          outstanding;
    int          error_count;
    int          tests_done;
    int          words_checked;

    basic_queue DUT (
        .aclk     (aclk),
        .areset_n (areset_n),
        .rx_tvalid(rx_tvalid),
        .rx_tdata (rx_tdata),
        .rx_tready(rx_tready),
        .tx_tready(tx_tready),
        .tx_tvalid(tx_tvalid),
        .tx_tdata (tx_tdata)
    );

    queue_checker #(
        .WIDTH   (WIDTH),
        .CAPACITY(CAPACITY)
    ) u_checker (
        .aclk         (aclk),
        .areset_n     (areset_n),
        .rx_tvalid    (rx_tvalid),
        .rx_tdata     (rx_tdata),
        .rx_tready    (rx_tready),
        .tx_tvalid    (tx_tvalid),
        .tx_tdata     (tx_tdata),
        .tx_tready    (tx_tready),
        .test_number  (test_number),
        .test_mode    (test_mode),
        .outstanding  (outstanding),
        .error_count  (error_count),
        .tests_done   (tests_done),
        .words_checked(words_checked)
    );

    always #20 aclk = ~aclk;  // 40 ns period.

    // Run limit from the stimulus length plus a drain margin.
    always @(posedge aclk) begin
        if (areset_n) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] value);
        return value * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int row_words(input int mode);
        return (mode == MODE_EXPLICIT) ? 3 : 2;
    endfunction

    // ************************************************************************
    // Stimulus, one row per cycle driven on the falling edge
    // ************************************************************************

    task automatic run_tests();
        int pos;
        int rows;
        int row;
        pos = 0;
        while (stim[pos] == HEADER_MARK && stim[pos + 1] != 8'h00) begin
            rows = int'(stim[pos + 3]);
            for (row = 0; row < rows; row++) begin
                @(negedge aclk);
                if (row == 0) begin
                    test_number = int'(stim[pos + 1]);
                    test_mode   = int'(stim[pos + 2]);
                    pos += 4;
                end
                rx_tvalid = stim[pos][0];
                rx_tdata  = stim[pos + 1];
                case (test_mode)
                    MODE_ALWAYS: tx_tready = 1'b1;
                    MODE_NEVER:  tx_tready = 1'b0;
                    MODE_RANDOM: begin
                        lcg_state = lcg_next(lcg_state);
                        tx_tready = lcg_state[31];
                    end
                    default:     tx_tready = stim[pos + 2][0];
                endcase
                pos += row_words(test_mode);
            end
        end
    endtask

    // Empties the queue so that leftovers show up in the last test.
    task automatic drain_queue();
        int waited;
        waited = 0;
        @(negedge aclk);
        rx_tvalid = 1'b0;
        tx_tready = 1'b1;
        while ((outstanding != 0 || tx_tvalid) && waited < DRAIN_CYCLES) begin
            @(negedge aclk);
            waited++;
        end
    endtask

    initial begin
        int   pos;
        int   total_cycles;
        logic stim_ok;
        areset_n    = 1'b0;
        rx_tvalid   = 1'b0;
        rx_tdata    = '0;
        tx_tready   = 1'b0;
        test_number = 0;
        test_mode   = MODE_ALWAYS;
        lcg_state   = 32'h41942643;
        $readmemh(STIM_FILE, stim);

        pos          = 0;
        total_cycles = 0;
        while (pos < STIM_DEPTH - 4 && stim[pos] == HEADER_MARK && stim[pos + 1] != 8'h00) begin
            total_cycles += int'(stim[pos + 3]);
            pos += 4 + int'(stim[pos + 3]) * row_words(int'(stim[pos + 2]));
        end
        stim_ok     = pos < STIM_DEPTH - 4 && stim[pos] == HEADER_MARK && total_cycles > 0;
        cycle_limit = total_cycles + 4 * CAPACITY;

        if (!stim_ok) begin
            $display("Stimulus file %s is missing or malformed", STIM_FILE);
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge aclk);
            @(negedge aclk);
            areset_n = 1'b1;
            run_tests();
            drain_queue();
            @(negedge aclk);
            test_number = 0;  // The checker closes the last test on this change.
            @(negedge aclk);
            $display("Summary: %0d tests, %0d words checked, %0d errors",
                     tests_done, words_checked, error_count);
            if (error_count == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

// File: flist.f
common/queue_pkg.sv
source/queue_write_stage.sv
queue_core/queue_memory.sv
queue_core/queue_usage_counter.sv
source/queue_read_fsm.sv
source/basic_queue.sv
bench/queue_checker.sv
bench/basic_queue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the queue and its testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module basic_queue_tb -f flist.f > build.log 2>&1 \
    && ./obj_dir/Vbasic_queue_tb > "$LOG" 2>&1 \
    || { echo "Build or simulation did not complete, see build.log and $LOG"; exit 1; }

grep -q "TB FAILED" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// File: bench/queue_stim.txt
// Header: FF <test> <mode> <cycles>, modes 00 always, 01 never, 02 random, 03 explicit.
// Rows: <rx_tvalid> <rx_tdata>, plus <tx_tready> in explicit mode; FF 00 00 00 ends.

FF 01 00 04
00 00  00 00  00 00  00 00

FF 02 00 0C
01 11  01 12
01 13  00 00
01 14  01 15
01 16  01 17
00 00  01 18
00 00  00 00

FF 03 03 0A
01 21 00
01 22 00
01 23 00
00 00 00
00 00 00
00 00 01
01 24 01
00 00 00
00 00 00
00 00 01

FF 04 01 14
01 40  01 41  01 42  01 43
01 44  01 45  01 46  01 47
01 48  01 49  01 4A  01 4B
01 4C  01 4D  01 4E  01 4F
01 50  01 51  01 52  01 53

FF 05 00 14
00 00  00 00  00 00  00 00
00 00  00 00  00 00  00 00
00 00  00 00  00 00  00 00
00 00  00 00  00 00  00 00
00 00  00 00  00 00  00 00

FF 06 02 14
01 80  00 81  01 82  01 83
00 84  01 85  01 86  00 87
01 88  01 89  01 8A  00 8B
00 8C  01 8D  00 8E  01 8F
01 90  01 91  00 92  01 93

FF 00 00 00
